// ==== src/i3c_daa_pkg.sv ====
`default_nettype none

package i3c_daa_pkg;

  // Provisional ID sent from pid[47] down to dcr[0]
  typedef struct packed {
    logic [47:0] pid;
    logic [7:0]  bcr;
    logic [7:0]  dcr;
  } daa_identity_t;

  typedef struct packed {
    logic req_bit;
    logic req_byte;
  } bus_rx_req_t;

  typedef struct packed {
    logic       req_bit;
    logic       req_byte;
    logic [7:0] value;
    logic       sel_od_pp;
  } bus_tx_req_t;

  // One-cycle flags from the bus monitor
  typedef struct packed {
    logic rstart_det;
    logic stop_det;
    logic scl_rise;
    logic scl_fall;
  } bus_events_t;

  // Broadcast address 7E with the read bit set
  localparam logic [7:0] BroadcastRead = 8'hFD;

endpackage

`default_nettype wire

// ==== src/i3c_bus_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module i3c_bus_monitor #(
  parameter int unsigned SyncStages = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     scl_i,
  input  logic                     sda_i,
  output logic                     scl_o,
  output logic                     sda_o,
  output i3c_daa_pkg::bus_events_t events_o
);

  logic [SyncStages-1:0] scl_sync_q;
  logic [SyncStages-1:0] sda_sync_q;
  logic scl_prev_q;
  logic sda_prev_q;
  i3c_daa_pkg::bus_events_t events_d;
  i3c_daa_pkg::bus_events_t events_q;

  // Idle bus is high on both lines
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
      events_q   <= '0;
    end else begin
      scl_sync_q <= {scl_sync_q[SyncStages-2:0], scl_i};
      sda_sync_q <= {sda_sync_q[SyncStages-2:0], sda_i};
      scl_prev_q <= scl_o;
      sda_prev_q <= sda_o;
      events_q   <= events_d;
    end
  end

  assign scl_o = scl_sync_q[SyncStages-1];
  assign sda_o = sda_sync_q[SyncStages-1];

  // SDA moving while SCL is high marks START or STOP
  always_comb begin
    events_d.rstart_det = scl_o & scl_prev_q & sda_prev_q & ~sda_o;
    events_d.stop_det   = scl_o & scl_prev_q & ~sda_prev_q & sda_o;
    events_d.scl_rise   = scl_o & ~scl_prev_q;
    events_d.scl_fall   = ~scl_o & scl_prev_q;
  end

  assign events_o = events_q;

endmodule

`default_nettype wire

// ==== src/i3c_bus_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module i3c_bus_rx (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     sda_i,
  input  i3c_daa_pkg::bus_events_t events_i,
  input  i3c_daa_pkg::bus_rx_req_t req_i,
  output logic [7:0]               data_o,
  output logic                     done_o
);

  logic [7:0] shift_q;
  logic [2:0] count_q;
  logic       done_q;
  logic       req_active;
  logic       bus_reset;
  logic       sample;

  assign req_active = req_i.req_bit | req_i.req_byte;
  assign bus_reset  = events_i.rstart_det | events_i.stop_det;
  // No sampling in the done cycle as the request is still the old one
  assign sample     = req_active & ~done_q & ~bus_reset & events_i.scl_rise;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (bus_reset || !req_active || done_q) begin
        count_q <= '0;
      end else if (sample) begin
        if (req_i.req_bit || count_q == 3'd7) begin
          done_q  <= 1'b1;
          count_q <= '0;
        end else begin
          count_q <= count_q + 3'd1;
        end
      end
    end
  end

  // MSB first so a single bit ends up in bit 0
  always_ff @(posedge clk_i) begin
    if (sample) begin
      shift_q <= {shift_q[6:0], sda_i};
    end
  end

  assign data_o = shift_q;
  assign done_o = done_q;

endmodule

`default_nettype wire

// ==== src/i3c_bus_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module i3c_bus_tx (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     sda_i,
  input  logic                     scl_i,
  input  i3c_daa_pkg::bus_events_t events_i,
  input  i3c_daa_pkg::bus_tx_req_t req_i,
  output logic                     done_o,
  output logic                     arbitration_lost_o,
  output logic                     sda_oe_o,
  output logic                     sel_od_pp_o
);

  logic       busy_q;
  logic       placed_q;
  logic       done_q;
  logic       lost_q;
  logic       sda_oe_q;
  logic       sel_q;
  logic [7:0] shift_q;
  logic [3:0] bits_left_q;
  logic       req_active;
  logic       load;
  logic       first_bit;

  assign req_active = req_i.req_bit | req_i.req_byte;
  assign load       = req_active & ~busy_q & ~done_q;
  assign first_bit  = req_i.req_byte ? req_i.value[7] : req_i.value[0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      placed_q    <= 1'b0;
      done_q      <= 1'b0;
      lost_q      <= 1'b0;
      sda_oe_q    <= 1'b0;
      sel_q       <= 1'b0;
      shift_q     <= '0;
      bits_left_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (events_i.rstart_det || events_i.stop_det) begin
        busy_q   <= 1'b0;
        placed_q <= 1'b0;
        sda_oe_q <= 1'b0;
      end else if (load) begin
        busy_q      <= 1'b1;
        lost_q      <= 1'b0;
        sel_q       <= req_i.sel_od_pp;
        shift_q     <= req_i.req_byte ? req_i.value : {req_i.value[0], 7'h00};
        bits_left_q <= req_i.req_byte ? 4'd8 : 4'd1;
        // SCL already low so the bit can go out right away
        if (!scl_i) begin
          sda_oe_q <= ~first_bit;
          placed_q <= 1'b1;
        end
      end else if (busy_q) begin
        if (!placed_q && events_i.scl_fall) begin
          sda_oe_q <= ~shift_q[7];
          placed_q <= 1'b1;
        end else if (placed_q && events_i.scl_rise) begin
          placed_q    <= 1'b0;
          shift_q     <= {shift_q[6:0], 1'b0};
          bits_left_q <= bits_left_q - 4'd1;
          if (shift_q[7] && !sda_i) begin
            // Someone else pulled low and won
            lost_q   <= 1'b1;
            sda_oe_q <= 1'b0;
            busy_q   <= 1'b0;
            done_q   <= 1'b1;
          end else if (bits_left_q == 4'd1) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
          end
        end
      end else if (events_i.scl_fall) begin
        // Last bit is held through SCL high and released here
        sda_oe_q <= 1'b0;
      end
    end
  end

  assign done_o             = done_q;
  assign arbitration_lost_o = lost_q;
  assign sda_oe_o           = sda_oe_q;
  assign sel_od_pp_o        = sel_q;

endmodule

`default_nettype wire

// ==== src/ccc_entdaa.sv ====
`timescale 1ns/1ps
`default_nettype none

module ccc_entdaa (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  i3c_daa_pkg::daa_identity_t identity_i,
  input  i3c_daa_pkg::daa_identity_t virtual_identity_i,
  input  logic                       process_virtual_i,
  input  logic                       start_daa_i,
  input  i3c_daa_pkg::bus_events_t   events_i,
  input  logic [7:0]                 rx_data_i,
  input  logic                       rx_done_i,
  input  logic                       tx_done_i,
  input  logic                       arbitration_lost_i,
  output i3c_daa_pkg::bus_rx_req_t   rx_req_o,
  output i3c_daa_pkg::bus_tx_req_t   tx_req_o,
  output logic                       done_daa_o,
  output logic [6:0]                 address_o,
  output logic                       address_valid_o
);

  typedef enum logic [3:0] {
    Idle            = 4'h0,
    WaitStart       = 4'h1,
    ReceiveRsvdByte = 4'h2,
    AckRsvdByte     = 4'h3,
    SendNack        = 4'h4,
    SendID          = 4'h5,
    PrepareIDBit    = 4'h6,
    SendIDBit       = 4'h7,
    LostArbitration = 4'h8,
    ReceiveAddr     = 4'h9,
    AckAddr         = 4'ha,
    Done            = 4'hb,
    Error           = 4'hc
  } state_e;

  state_e      state_q, state_d;
  logic [6:0]  id_bit_count;
  logic        load_id_counter;
  logic        tick_id_counter;
  logic        reserved_byte_ok;
  logic        parity_ok;
  logic [63:0] device_id;

  assign reserved_byte_ok = (rx_data_i == i3c_daa_pkg::BroadcastRead);
  // Odd parity over address and parity bit
  assign parity_ok        = ^rx_data_i;
  assign device_id        = process_virtual_i ? virtual_identity_i : identity_i;
  assign done_daa_o       = (state_q == Done);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_bit_count <= '0;
    end else if (load_id_counter) begin
      id_bit_count <= 7'd64;
    end else if (tick_id_counter) begin
      id_bit_count <= id_bit_count - 7'd1;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle:            if (start_daa_i) state_d = WaitStart;
      WaitStart:       if (events_i.rstart_det) state_d = ReceiveRsvdByte;
      ReceiveRsvdByte: begin
        if (rx_done_i) begin
          state_d = reserved_byte_ok ? AckRsvdByte : SendNack;
        end
      end
      AckRsvdByte:     if (tx_done_i) state_d = SendID;
      SendNack:        if (tx_done_i) state_d = Error;
      SendID:          state_d = PrepareIDBit;
      PrepareIDBit:    if (id_bit_count != '0) state_d = SendIDBit;
      SendIDBit: begin
        if (tx_done_i) begin
          if (arbitration_lost_i) begin
            state_d = LostArbitration;
          end else if (id_bit_count == '0) begin
            state_d = ReceiveAddr;
          end else begin
            state_d = PrepareIDBit;
          end
        end
      end
      LostArbitration: state_d = Error;
      ReceiveAddr: begin
        if (rx_done_i) begin
          state_d = parity_ok ? AckAddr : SendNack;
        end
      end
      AckAddr:         if (tx_done_i) state_d = Done;
      Done:            state_d = Idle;
      Error:           state_d = Idle;
      default:         state_d = Idle;
    endcase
  end

  always_comb begin
    rx_req_o        = '0;
    tx_req_o        = '0;
    load_id_counter = 1'b0;
    tick_id_counter = 1'b0;
    address_o       = '0;
    address_valid_o = 1'b0;
    unique case (state_q)
      ReceiveRsvdByte: rx_req_o.req_byte = 1'b1;
      AckRsvdByte:     tx_req_o.req_bit = 1'b1;
      SendNack: begin
        tx_req_o.req_bit = 1'b1;
        tx_req_o.value   = 8'h01;
      end
      SendID:          load_id_counter = 1'b1;
      PrepareIDBit:    tick_id_counter = 1'b1;
      SendIDBit: begin
        tx_req_o.req_bit = 1'b1;
        tx_req_o.value   = {7'h00, device_id[id_bit_count[5:0]]};
      end
      ReceiveAddr: begin
        rx_req_o.req_byte = 1'b1;
        // Reported on completion with parity checked separately
        if (rx_done_i) begin
          address_valid_o = 1'b1;
          address_o       = rx_data_i[7:1];
        end
      end
      AckAddr:         tx_req_o.req_bit = 1'b1;
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else if (events_i.stop_det) begin
      state_q <= Done;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// ==== src/i3c_daa_target.sv ====
`timescale 1ns/1ps
`default_nettype none

module i3c_daa_target #(
  parameter int unsigned SyncStages = 2
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       scl_i,
  input  logic                       sda_i,
  input  i3c_daa_pkg::daa_identity_t identity_i,
  input  i3c_daa_pkg::daa_identity_t virtual_identity_i,
  input  logic                       process_virtual_i,
  input  logic                       start_daa_i,
  output logic                       sda_oe_o,
  output logic                       sel_od_pp_o,
  output logic                       done_daa_o,
  output logic [6:0]                 address_o,
  output logic                       address_valid_o
);

  logic                     scl_sync;
  logic                     sda_sync;
  i3c_daa_pkg::bus_events_t events;
  i3c_daa_pkg::bus_rx_req_t rx_req;
  i3c_daa_pkg::bus_tx_req_t tx_req;
  logic [7:0]               rx_data;
  logic                     rx_done;
  logic                     tx_done;
  logic                     arbitration_lost;

  i3c_bus_monitor #(
    .SyncStages(SyncStages)
  ) u_bus_monitor (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .scl_i   (scl_i),
    .sda_i   (sda_i),
    .scl_o   (scl_sync),
    .sda_o   (sda_sync),
    .events_o(events)
  );

  i3c_bus_rx u_bus_rx (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .sda_i   (sda_sync),
    .events_i(events),
    .req_i   (rx_req),
    .data_o  (rx_data),
    .done_o  (rx_done)
  );

  i3c_bus_tx u_bus_tx (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .sda_i             (sda_sync),
    .scl_i             (scl_sync),
    .events_i          (events),
    .req_i             (tx_req),
    .done_o            (tx_done),
    .arbitration_lost_o(arbitration_lost),
    .sda_oe_o          (sda_oe_o),
    .sel_od_pp_o       (sel_od_pp_o)
  );

  ccc_entdaa u_ccc_entdaa (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .identity_i        (identity_i),
    .virtual_identity_i(virtual_identity_i),
    .process_virtual_i (process_virtual_i),
    .start_daa_i       (start_daa_i),
    .events_i          (events),
    .rx_data_i         (rx_data),
    .rx_done_i         (rx_done),
    .tx_done_i         (tx_done),
    .arbitration_lost_i(arbitration_lost),
    .rx_req_o          (rx_req),
    .tx_req_o          (tx_req),
    .done_daa_o        (done_daa_o),
    .address_o         (address_o),
    .address_valid_o   (address_valid_o)
  );

endmodule

`default_nettype wire

// ==== dv/daa_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module daa_checker (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         scl_i,
  input  logic         sda_oe_i,
  input  logic         sel_od_pp_i,
  input  logic         done_daa_i,
  input  logic [6:0]   address_i,
  input  logic         address_valid_i,
  input  logic [127:0] name_i,
  input  logic [63:0]  exp_id_i,
  input  logic [7:0]   rsvd_i,
  input  logic [6:0]   addr_i,
  input  logic         flip_i,
  input  int           loss_i,
  input  int           stop_i,
  input  logic [2:0]   slot_kind_i,
  input  int           slot_idx_i,
  input  logic         stopped_i,
  input  logic         case_end_i,
  output int           pass_count_o,
  output int           fail_count_o
);

  localparam logic [2:0] SlotRsvdAck = 3'd2;
  localparam logic [2:0] SlotId      = 3'd3;
  localparam logic [2:0] SlotAddrAck = 3'd4;

  int   slot_errs;
  int   clk_errs;
  int   errs_at_start;
  int   valid_seen;
  int   done_before;
  int   done_after;
  int   errs;
  logic reset_checked;
  logic exp_oe;
  logic rsvd_ok;
  logic full_path;

  assign rsvd_ok   = (rsvd_i == i3c_daa_pkg::BroadcastRead);
  // Address phase only reached without NACK, lost bit or early STOP
  assign full_path = rsvd_ok && loss_i < 0 && stop_i < 0;

  initial begin
    slot_errs     = 0;
    clk_errs      = 0;
    errs_at_start = 0;
    valid_seen    = 0;
    done_before   = 0;
    done_after    = 0;
    reset_checked = 1'b0;
    pass_count_o  = 0;
    fail_count_o  = 0;
  end

  // Target pulls SDA low for a 0 so oe is the inverse of the bit
  always @(posedge scl_i) begin
    exp_oe = 1'b0;
    case (slot_kind_i)
      SlotRsvdAck: exp_oe = rsvd_ok;
      SlotId: begin
        if (rsvd_ok && (loss_i < 0 || slot_idx_i <= loss_i)) begin
          exp_oe = ~exp_id_i[63 - slot_idx_i];
        end
      end
      SlotAddrAck: exp_oe = full_path && !flip_i;
      default: exp_oe = 1'b0;
    endcase
    if (slot_kind_i != 3'd0 && sda_oe_i !== exp_oe) begin
      $display("ERR @%0t: %0s slot kind %0d index %0d sda_oe_o=%b expected %b",
               $time, name_i, slot_kind_i, slot_idx_i, sda_oe_i, exp_oe);
      slot_errs++;
    end
  end

  always @(negedge clk_i) begin
    if (rst_ni && !reset_checked) begin
      reset_checked = 1'b1;
      if ({sda_oe_i, sel_od_pp_i, done_daa_i, address_valid_i} !== 4'b0000) begin
        $display("ERR @%0t: outputs not idle after reset", $time);
        clk_errs++;
      end
    end
    if (rst_ni && sel_od_pp_i !== 1'b0) begin
      $display("ERR @%0t: %0s sel_od_pp_o is set", $time, name_i);
      clk_errs++;
    end
    if (address_valid_i && !stopped_i) begin
      valid_seen++;
      if (address_i !== addr_i) begin
        $display("ERR @%0t: %0s address_o=%h expected %h", $time, name_i, address_i, addr_i);
        clk_errs++;
      end
    end
    if (done_daa_i) begin
      if (stopped_i) begin
        done_after++;
      end else begin
        done_before++;
      end
    end
    if (case_end_i) begin
      if (valid_seen != (full_path ? 1 : 0)) begin
        $display("ERR @%0t: %0s address_valid_o pulsed %0d times", $time, name_i, valid_seen);
        clk_errs++;
      end
      if (done_before != ((full_path && !flip_i) ? 1 : 0)) begin
        $display("ERR @%0t: %0s done_daa_o pulsed %0d times before STOP",
                 $time, name_i, done_before);
        clk_errs++;
      end
      if (done_after == 0) begin
        $display("ERR @%0t: %0s no done_daa_o after STOP", $time, name_i);
        clk_errs++;
      end
      errs = slot_errs + clk_errs - errs_at_start;
      if (errs == 0) begin
        pass_count_o++;
        $display("PASS %0s", name_i);
      end else begin
        fail_count_o++;
        $display("FAIL %0s with %0d errors", name_i, errs);
      end
      errs_at_start = slot_errs + clk_errs;
      valid_seen    = 0;
      done_before   = 0;
      done_after    = 0;
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_i3c_daa.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_i3c_daa;

  localparam int MaxCases  = 16;
  localparam int ClkPeriod = 40;
  localparam logic [2:0] SlotNone    = 3'd0;
  localparam logic [2:0] SlotCtrl    = 3'd1;
  localparam logic [2:0] SlotRsvdAck = 3'd2;
  localparam logic [2:0] SlotId      = 3'd3;
  localparam logic [2:0] SlotAddrAck = 3'd4;

  logic clk;
  logic rst_n;
  logic scl;
  logic sda_rel;
  wire  sda;
  logic start_daa;
  logic process_virtual;
  i3c_daa_pkg::daa_identity_t identity;
  i3c_daa_pkg::daa_identity_t virtual_identity;
  logic       sda_oe;
  logic       sel_od_pp;
  logic       done_daa;
  logic [6:0] address;
  logic       address_valid;

  logic [127:0] cur_name;
  logic [63:0]  exp_id;
  logic [7:0]   cur_rsvd;
  logic [6:0]   cur_addr;
  logic         cur_flip;
  int           cur_loss;
  int           cur_stop;
  logic [2:0]   slot_kind;
  int           slot_idx;
  logic         stopped;
  logic         case_end;
  int           pass_count;
  int           fail_count;

  logic [127:0] c_name [MaxCases];
  logic [63:0]  c_phys [MaxCases];
  logic [63:0]  c_virt [MaxCases];
  logic         c_vflag [MaxCases];
  logic [7:0]   c_rsvd [MaxCases];
  logic [6:0]   c_addr [MaxCases];
  logic         c_flip [MaxCases];
  int           c_loss [MaxCases];
  int           c_stop [MaxCases];
  int           ncases;
  integer       seed;

  // Open-drain line that either side can pull low
  assign sda = sda_rel & ~sda_oe;

  i3c_daa_target #(
    .SyncStages(2)
  ) uut (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .scl_i             (scl),
    .sda_i             (sda),
    .identity_i        (identity),
    .virtual_identity_i(virtual_identity),
    .process_virtual_i (process_virtual),
    .start_daa_i       (start_daa),
    .sda_oe_o          (sda_oe),
    .sel_od_pp_o       (sel_od_pp),
    .done_daa_o        (done_daa),
    .address_o         (address),
    .address_valid_o   (address_valid)
  );

  daa_checker u_checker (
    .clk_i(clk), .rst_ni(rst_n), .scl_i(scl), .sda_oe_i(sda_oe),
    .sel_od_pp_i(sel_od_pp), .done_daa_i(done_daa), .address_i(address),
    .address_valid_i(address_valid), .name_i(cur_name), .exp_id_i(exp_id),
    .rsvd_i(cur_rsvd), .addr_i(cur_addr), .flip_i(cur_flip), .loss_i(cur_loss),
    .stop_i(cur_stop), .slot_kind_i(slot_kind), .slot_idx_i(slot_idx),
    .stopped_i(stopped), .case_end_i(case_end), .pass_count_o(pass_count),
    .fail_count_o(fail_count)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  task automatic tick(input int n);
    repeat (n) @(negedge clk);
  endtask

  // One SCL period of 8 clocks with 6 low and 2 high
  task automatic bus_slot(input logic bit_val, input logic [2:0] kind, input int idx);
    scl       <= 1'b0;
    slot_kind <= kind;
    slot_idx  <= idx;
    tick(2);
    sda_rel <= bit_val;
    tick(4);
    scl <= 1'b1;
    tick(2);
  endtask

  task automatic load_cases();
    int           fd;
    int           r;
    string        line;
    logic [127:0] nm;
    logic [47:0]  p0, p1;
    logic [7:0]   b0, d0, b1, d1, rs;
    logic [6:0]   ad;
    int           vf, fl, lo, st;
    fd = $fopen("dv/daa_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file dv/daa_cases.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#" && ncases < MaxCases) begin
          r = $sscanf(line, "%s %h %h %h %h %h %h %d %h %h %d %d %d",
                      nm, p0, b0, d0, p1, b1, d1, vf, rs, ad, fl, lo, st);
          if (r == 13) begin
            c_name[ncases]  = nm;
            // An all-zero PID stands for random padding
            c_phys[ncases]  = (p0 == '0) ? {$random(seed), $random(seed)} : {p0, b0, d0};
            c_virt[ncases]  = (p1 == '0) ? {$random(seed), $random(seed)} : {p1, b1, d1};
            c_vflag[ncases] = vf[0];
            c_rsvd[ncases]  = rs;
            c_addr[ncases]  = ad;
            c_flip[ncases]  = fl[0];
            c_loss[ncases]  = lo;
            c_stop[ncases]  = st;
            ncases++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_case(input int i);
    int         b;
    int         k;
    int         nid;
    logic [7:0] abyte;
    identity         <= c_phys[i];
    virtual_identity <= c_virt[i];
    process_virtual  <= c_vflag[i];
    exp_id           <= c_vflag[i] ? c_virt[i] : c_phys[i];
    cur_name         <= c_name[i];
    cur_rsvd         <= c_rsvd[i];
    cur_addr         <= c_addr[i];
    cur_flip         <= c_flip[i];
    cur_loss         <= c_loss[i];
    cur_stop         <= c_stop[i];
    start_daa        <= 1'b1;
    tick(1);
    start_daa <= 1'b0;
    tick(2);
    // Repeated START with SCL high
    sda_rel <= 1'b0;
    tick(4);
    for (b = 7; b >= 0; b--) bus_slot(c_rsvd[i][b], SlotCtrl, b);
    bus_slot(1'b1, SlotRsvdAck, 0);
    nid = (c_stop[i] >= 0) ? c_stop[i] : 64;
    for (k = 0; k < nid; k++) bus_slot(k != c_loss[i], SlotId, k);
    if (c_stop[i] < 0) begin
      abyte = {c_addr[i], ~^c_addr[i] ^ c_flip[i]};
      for (b = 7; b >= 0; b--) bus_slot(abyte[b], SlotCtrl, b);
      bus_slot(1'b1, SlotAddrAck, 0);
    end
    // STOP
    scl       <= 1'b0;
    slot_kind <= SlotNone;
    tick(2);
    sda_rel <= 1'b0;
    tick(4);
    scl <= 1'b1;
    tick(4);
    sda_rel <= 1'b1;
    stopped <= 1'b1;
    tick(8);
    case_end <= 1'b1;
    tick(1);
    case_end <= 1'b0;
    stopped  <= 1'b0;
    tick(2);
  endtask

  initial begin
    seed             = 7343;
    ncases           = 0;
    rst_n            = 1'b0;
    scl              = 1'b1;
    sda_rel          = 1'b1;
    start_daa        = 1'b0;
    process_virtual  = 1'b0;
    identity         = '0;
    virtual_identity = '0;
    cur_name         = '0;
    exp_id           = '0;
    cur_rsvd         = '0;
    cur_addr         = '0;
    cur_flip         = 1'b0;
    cur_loss         = -1;
    cur_stop         = -1;
    slot_kind        = SlotNone;
    slot_idx         = 0;
    stopped          = 1'b0;
    case_end         = 1'b0;
    load_cases();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n <= 1'b1;
    tick(4);
    if (ncases == 0) begin
      $display("No test cases could be read");
      $display("Verification failed");
    end else begin
      for (int i = 0; i < ncases; i++) run_case(i);
      tick(4);
      $display("Tests finished: %0d passed, %0d failed", pass_count, fail_count);
      if (fail_count == 0 && pass_count == ncases) begin
        $display("Verification passed");
      end else begin
        $display("Verification failed");
      end
    end
    $finish;
  end

  // Each case needs well under 120 SCL periods
  initial begin
    wait (rst_n === 1'b1);
    #(ncases * 120 * 8 * ClkPeriod);
    $display("Timeout: the tests did not finish in the expected time");
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/daa_cases.txt ====
# name phys_pid bcr dcr virt_pid bcr dcr virtual rsvd_byte addr parity_flip loss_bit stop_bit
# a PID of 0 means random data, loss_bit and stop_bit are -1 when unused
good_phys        0123456789ab 5a c3 000000000000 00 00 0 fd 2a 0 -1 -1
good_virt        000000000000 00 00 fedcba987654 0f 81 1 fd 51 0 -1 -1
rsvd_write_bit   0123456789ab 5a c3 000000000000 00 00 0 fc 10 0 -1 -1
rsvd_7c          0123456789ab 5a c3 000000000000 00 00 0 f9 10 0 -1 -1
arb_lost_bit7    0123456789ab 5a c3 000000000000 00 00 0 fd 33 0 7 -1
arb_lost_virt41  000000000000 00 00 fedcba987654 0f 81 1 fd 33 0 41 -1
arb_lost_last    0123456789ab 5a c3 000000000000 00 00 0 fd 33 0 63 -1
parity_error     0123456789ab 5a c3 000000000000 00 00 0 fd 3c 1 -1 -1
stop_mid_id      0123456789ab 5a c3 000000000000 00 00 0 fd 12 0 -1 21
good_after_stop  fedcba987654 0f 81 000000000000 00 00 0 fd 7f 0 -1 -1
good_both_virt   0123456789ab 5a c3 fedcba987654 0f 81 1 fd 01 0 -1 -1
good_both_phys   0123456789ab 5a c3 fedcba987654 0f 81 0 fd 08 0 -1 -1

// ==== project.f ====
src/i3c_daa_pkg.sv
src/i3c_bus_monitor.sv
src/i3c_bus_rx.sv
src/i3c_bus_tx.sv
src/ccc_entdaa.sv
src/i3c_daa_target.sv
dv/daa_checker.sv
dv/tb_i3c_daa.sv

// ==== Bender.yml ====
package:
  name: i3c_daa_target

sources:
  - src/i3c_daa_pkg.sv
  - src/i3c_bus_monitor.sv
  - src/i3c_bus_rx.sv
  - src/i3c_bus_tx.sv
  - src/ccc_entdaa.sv
  - src/i3c_daa_target.sv
  - target: test
    files:
      - dv/daa_checker.sv
      - dv/tb_i3c_daa.sv
